// ==== hw/stack_pkg.sv ====
// Stack geometry constants with word, depth, rotate address and fault count types
`default_nettype none

package stack_pkg;

  // Number of address bits for one stack entry
  localparam int STACK_DEPTH_LOG2 = 4;

  // Entries in the stack, top included
  localparam int STACK_DEPTH = 1 << STACK_DEPTH_LOG2;

  // Data word width
  localparam int WORD_WIDTH = 32;

  // Width of the overflow event counter
  localparam int FAULT_COUNT_WIDTH = 8;

  // One stack word
  typedef logic [WORD_WIDTH-1:0] word_t;

  // Depth counter, wraps to zero on overflow
  typedef logic [STACK_DEPTH_LOG2-1:0] depth_t;

  // Rotate address
  // Value 0 names the second entry, so the top itself is never addressed
  typedef logic [STACK_DEPTH_LOG2-1:0] rot_addr_t;

  // Saturating overflow count
  typedef logic [FAULT_COUNT_WIDTH-1:0] fault_count_t;

endpackage : stack_pkg

`default_nettype wire

// ==== hw/isa_pkg.sv ====
// Opcode enum and the stack movement encoding shared by ALU and stack
`default_nettype none

package isa_pkg;

  // Opcode field width
  localparam int OP_WIDTH = 4;

  // Movement field width
  localparam int MOVE_WIDTH = 2;

  // One opcode per cycle, nop means idle
  typedef enum logic [OP_WIDTH-1:0] {
    op_nop   = 4'h0,
    op_push  = 4'h1,
    op_drop  = 4'h2,
    op_drop2 = 4'h3,
    op_dup   = 4'h4,
    op_add   = 4'h5,
    op_sub   = 4'h6,
    op_and   = 4'h7,
    op_xor   = 4'h8,
    op_rot   = 4'h9
  } op_t;

  // Stack movement for one cycle
  typedef enum logic [MOVE_WIDTH-1:0] {
    move_hold = 2'b00,
    move_push = 2'b01,
    move_pop  = 2'b10,
    move_pop2 = 2'b11
  } move_t;

endpackage : isa_pkg

`default_nettype wire

// ==== hw/dstack_cell.sv ====
// One shifting stack cell that holds, pushes, pops or pops twice
`default_nettype none

module dstack_cell (
  input  wire                 clk,
  input  wire isa_pkg::move_t movement,
  input  wire stack_pkg::word_t above,
  input  wire stack_pkg::word_t below,
  input  wire stack_pkg::word_t below_twice,
  output stack_pkg::word_t    value
);
  import stack_pkg::*;
  import isa_pkg::*;

  word_t next_value;

  // Pick the source for this cell
  always_comb begin
    case (movement)
      // Entry above moves down into this cell
      move_push: next_value = above;
      // Entry below moves up
      move_pop:  next_value = below;
      // Two entries consumed
      move_pop2: next_value = below_twice;
      default:   next_value = value;
    endcase
  end

  // Payload register
  always_ff @(posedge clk) begin
    value <= next_value;
  end

endmodule : dstack_cell

`default_nettype wire

// ==== hw/dstack.sv ====
// Data stack with registered top, shifting cells, rotate control, depth and overflow
`default_nettype none

module dstack (
  input  wire                      clk,
  input  wire                      reset,
  input  wire isa_pkg::move_t      movement,
  input  wire                      rotate,
  input  wire stack_pkg::rot_addr_t rot_addr,
  input  wire stack_pkg::word_t    next_top,
  output stack_pkg::word_t         top,
  output stack_pkg::word_t         second,
  output stack_pkg::word_t         third,
  output stack_pkg::word_t         rot_val,
  output logic                     overflow
);
  import stack_pkg::*;
  import isa_pkg::*;

  // Entry 0 is the top register
  // Two extra slots past the bottom feed the last two cells
  wire word_t elements [0:STACK_DEPTH+1];

  // Index of the entry brought up by a rotate
  wire [STACK_DEPTH_LOG2:0] rot_idx;

  depth_t depth;

  assign elements[0] = top;

  // Nothing lives below the bottom cell
  assign elements[STACK_DEPTH]   = 'x;
  assign elements[STACK_DEPTH+1] = 'x;

  assign second = elements[1];
  assign third  = elements[2];

  // Rotate addresses count from the second entry
  assign rot_idx = {1'b0, rot_addr} + 1'b1;
  assign rot_val = elements[rot_idx];

  // Push into a full stack loses the bottom entry
  // Depth wraps to zero at the same edge
  assign overflow = (movement == move_push) && (depth == depth_t'(STACK_DEPTH - 1));

  genvar i;
  generate
    for (i = 1; i < STACK_DEPTH; i++) begin : g_cell
      move_t cell_move;

      // On rotate every cell down to the rotated entry takes the one above
      // Deeper cells keep the requested movement
      assign cell_move = (rotate && (rot_addr_t'(i - 1) <= rot_addr)) ? move_push
                                                                         : movement;

      dstack_cell i_cell (
        .clk        (clk),
        .movement   (cell_move),
        .above      (elements[i-1]),
        .below      (elements[i+1]),
        .below_twice(elements[i+2]),
        .value      (elements[i])
      );
    end
  endgenerate

  // Top reloads from the ALU on every cycle including rotate
  always_ff @(posedge clk) begin
    top <= next_top;
  end

  // Depth tracking
  always_ff @(posedge clk) begin
    if (reset) begin
      depth <= '0;
    end else begin
      case (movement)
        move_push: depth <= depth + depth_t'(1);
        move_pop:  depth <= depth - depth_t'(1);
        move_pop2: depth <= depth - depth_t'(2);
        default:   depth <= depth;
      endcase
    end
  end

  // The ALU only requests a rotate on a cycle that does not move the stack
  a_rotate_on_hold: assert property (
    @(posedge clk) disable iff (reset)
    rotate |-> (movement == move_hold)
  );

endmodule : dstack

`default_nettype wire

// ==== hw/stack_alu.sv ====
// Opcode decode into stack movement, rotate request and next top value
`default_nettype none

module stack_alu (
  input  wire isa_pkg::op_t        op,
  input  wire stack_pkg::word_t    imm,
  input  wire                      halt,
  input  wire stack_pkg::word_t    top,
  input  wire stack_pkg::word_t    second,
  input  wire stack_pkg::word_t    third,
  input  wire stack_pkg::word_t    rot_val,
  output isa_pkg::move_t           movement,
  output logic                     rotate,
  output stack_pkg::rot_addr_t     rot_addr,
  output stack_pkg::word_t         next_top
);
  import stack_pkg::*;
  import isa_pkg::*;

  op_t op_eff;

  // Frozen core sees only nops
  assign op_eff = halt ? op_nop : op;

  // Rotate target from the low immediate bits
  assign rot_addr = rot_addr_t'(imm[STACK_DEPTH_LOG2-1:0]);

  always_comb begin
    // Idle by default
    movement = move_hold;
    rotate   = 1'b0;
    next_top = top;

    case (op_eff)
      op_push: begin
        movement = move_push;
        next_top = imm;
      end
      // Copy of top pushed down
      op_dup: begin
        movement = move_push;
        next_top = top;
      end
      op_drop: begin
        movement = move_pop;
        next_top = second;
      end
      op_drop2: begin
        movement = move_pop2;
        next_top = third;
      end
      // Binary ops consume top and second, leave result on top
      op_add: begin
        movement = move_pop;
        next_top = second + top;
      end
      op_sub: begin
        movement = move_pop;
        next_top = second - top;
      end
      op_and: begin
        movement = move_pop;
        next_top = second & top;
      end
      op_xor: begin
        movement = move_pop;
        next_top = second ^ top;
      end
      // Named entry comes up, the ones above shift down
      op_rot: begin
        rotate   = 1'b1;
        next_top = rot_val;
      end
      default: begin
        movement = move_hold;
        next_top = top;
      end
    endcase
  end

endmodule : stack_alu

`default_nettype wire

// ==== hw/fault_regs.sv ====
// Sticky overflow flag, saturating overflow counter, clear strobe and halt gate
`default_nettype none

module fault_regs (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  overflow,
  input  wire                  fault_clear,
  input  wire                  halt_on_fault,
  output logic                 overflow_flag,
  output stack_pkg::fault_count_t overflow_count,
  output logic                 halt
);
  import stack_pkg::*;

  // Counter stops here
  localparam fault_count_t COUNT_MAX = '1;

  // Sticky flag
  // Clear wins over a same-cycle overflow
  always_ff @(posedge clk) begin
    if (reset) begin
      overflow_flag <= 1'b0;
    end else if (fault_clear) begin
      overflow_flag <= 1'b0;
    end else if (overflow) begin
      overflow_flag <= 1'b1;
    end
  end

  // Saturating count of overflow events
  always_ff @(posedge clk) begin
    if (reset) begin
      overflow_count <= '0;
    end else if (fault_clear) begin
      overflow_count <= '0;
    end else if (overflow && (overflow_count != COUNT_MAX)) begin
      overflow_count <= overflow_count + fault_count_t'(1);
    end
  end

  // Freeze the ALU once a fault is latched and halting is enabled
  assign halt = overflow_flag && halt_on_fault;

  // Count only goes down through clear or reset
  a_count_monotonic: assert property (
    @(posedge clk) disable iff (reset)
    (!$past(reset) && !$past(fault_clear)) |-> (overflow_count >= $past(overflow_count))
  );

endmodule : fault_regs

`default_nettype wire

// ==== hw/stack_core.sv ====
// Top level wiring of stack ALU, fault registers and data stack
`default_nettype none

module stack_core (
  input  wire                     clk,
  input  wire                     reset,
  input  wire isa_pkg::op_t       op,
  input  wire stack_pkg::word_t   imm,
  input  wire                     fault_clear,
  input  wire                     halt_on_fault,
  output wire stack_pkg::word_t   top,
  output wire stack_pkg::word_t   second,
  output wire stack_pkg::word_t   third,
  output wire                     overflow_flag,
  output wire stack_pkg::fault_count_t overflow_count,
  output wire                     halted
);
  import stack_pkg::*;
  import isa_pkg::*;

  // ALU to stack
  wire move_t     movement;
  wire            rotate;
  wire rot_addr_t rot_addr;
  wire word_t     next_top;

  // Stack back to ALU and faults
  wire word_t     rot_val;
  wire            overflow;

  stack_alu i_alu (
    .op      (op),
    .imm     (imm),
    .halt    (halted),
    .top     (top),
    .second  (second),
    .third   (third),
    .rot_val (rot_val),
    .movement(movement),
    .rotate  (rotate),
    .rot_addr(rot_addr),
    .next_top(next_top)
  );

  fault_regs i_faults (
    .clk           (clk),
    .reset         (reset),
    .overflow      (overflow),
    .fault_clear   (fault_clear),
    .halt_on_fault (halt_on_fault),
    .overflow_flag (overflow_flag),
    .overflow_count(overflow_count),
    .halt          (halted)
  );

  dstack i_dstack (
    .clk     (clk),
    .reset   (reset),
    .movement(movement),
    .rotate  (rotate),
    .rot_addr(rot_addr),
    .next_top(next_top),
    .top     (top),
    .second  (second),
    .third   (third),
    .rot_val (rot_val),
    .overflow(overflow)
  );

endmodule : stack_core

`default_nettype wire

// ==== tb/tb_stack_core.sv ====
// Testbench for the stack core with file driven vectors, an array reference model and a watchdog
`default_nettype none

module tb_stack_core;
  timeunit 1ns;
  timeprecision 1ps;

  import stack_pkg::*;
  import isa_pkg::*;

  localparam int CLK_HALF_NS     = 50;
  localparam int CLK_PERIOD_NS   = 2 * CLK_HALF_NS;
  localparam int RESET_CYCLES    = 16;
  localparam int SLACK_CYCLES    = 20;
  localparam int DRIVE_DELAY_NS  = 10;
  localparam int SAMPLE_DELAY_NS = 5;

  logic         clk;
  logic         reset;
  op_t          op;
  word_t        imm;
  logic         fault_clear;
  logic         halt_on_fault;
  word_t        top;
  word_t        second;
  word_t        third;
  logic         overflow_flag;
  fault_count_t overflow_count;
  logic         halted;

  // Vectors as read from the data file
  logic [3:0] vec_op [$];
  word_t      vec_imm [$];
  logic       vec_clear [$];
  logic       vec_hof [$];
  int         num_vectors;
  bit         vectors_loaded;

  // Reference model, entry 0 is the top
  word_t        m_stk [0:STACK_DEPTH-1];
  depth_t       m_depth;
  logic         m_flag;
  fault_count_t m_count;

  stack_core i_dut (
    .clk           (clk),
    .reset         (reset),
    .op            (op),
    .imm           (imm),
    .fault_clear   (fault_clear),
    .halt_on_fault (halt_on_fault),
    .top           (top),
    .second        (second),
    .third         (third),
    .overflow_flag (overflow_flag),
    .overflow_count(overflow_count),
    .halted        (halted)
  );

  initial clk = 1'b0;
  always #(CLK_HALF_NS) clk = ~clk;

  // Compare one value, stop at the first mismatch
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h got %h at %0t", name, expected, actual, $time);
      $display("STATUS: FAIL");
      $fatal(1, "Output mismatch");
    end
  endtask

  // Columns are op, imm, clear and halt enable in hex, other lines are skipped
  task automatic load_vectors();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_imm;
    logic [31:0] f_clr;
    logic [31:0] f_hof;
    fd = $fopen("tb/stack_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tb/stack_input.txt");
      $display("STATUS: FAIL");
      $fatal(1, "No stimulus");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        fields = $sscanf(line, "%h %h %h %h", f_op, f_imm, f_clr, f_hof);
        if (fields == 4) begin
          vec_op.push_back(f_op[3:0]);
          vec_imm.push_back(f_imm);
          vec_clear.push_back(f_clr[0]);
          vec_hof.push_back(f_hof[0]);
        end
      end
      $fclose(fd);
      num_vectors = vec_op.size();
    end
  endtask

  // Push moves every entry one place deeper, the bottom entry is lost
  task automatic shift_in_word(input word_t value);
    for (int i = STACK_DEPTH - 1; i > 0; i--) begin
      m_stk[i] = m_stk[i-1];
    end
    m_stk[0] = value;
    m_depth  = m_depth + depth_t'(1);
  endtask

  // Pop by one or two, nothing valid comes up from below the bottom
  task automatic shift_out_words(input int count, input word_t value);
    for (int i = 1; i < STACK_DEPTH; i++) begin
      if (i + count < STACK_DEPTH) begin
        m_stk[i] = m_stk[i+count];
      end else begin
        m_stk[i] = 'x;
      end
    end
    m_stk[0] = value;
    m_depth  = m_depth - depth_t'(count);
  endtask

  // Entry addr+1 comes up, the ones above it sink by one
  task automatic rotate_entries(input int addr);
    word_t picked;
    picked = m_stk[addr+1];
    for (int i = addr + 1; i > 0; i--) begin
      m_stk[i] = m_stk[i-1];
    end
    m_stk[0] = picked;
  endtask

  // Advance the model by the vector applied at the last edge
  task automatic apply_vector(input logic [3:0] op_in, input word_t imm_in,
                              input logic clr_in, input logic hof_in);
    op_t  op_eff;
    logic ovf;
    ovf    = 1'b0;
    op_eff = (m_flag && hof_in) ? op_nop : op_t'(op_in);
    if ((op_eff == op_push) || (op_eff == op_dup)) begin
      ovf = (m_depth == depth_t'(STACK_DEPTH - 1));
    end
    case (op_eff)
      op_push:  shift_in_word(imm_in);
      op_dup:   shift_in_word(m_stk[0]);
      op_drop:  shift_out_words(1, m_stk[1]);
      op_drop2: shift_out_words(2, m_stk[2]);
      op_add:   shift_out_words(1, m_stk[1] + m_stk[0]);
      op_sub:   shift_out_words(1, m_stk[1] - m_stk[0]);
      op_and:   shift_out_words(1, m_stk[1] & m_stk[0]);
      op_xor:   shift_out_words(1, m_stk[1] ^ m_stk[0]);
      op_rot:   rotate_entries(int'(imm_in[STACK_DEPTH_LOG2-1:0]));
      default:  m_stk[0] = m_stk[0];
    endcase
    // Clear beats a same cycle overflow
    if (clr_in) begin
      m_flag  = 1'b0;
      m_count = '0;
    end else if (ovf) begin
      m_flag = 1'b1;
      if (m_count != '1) begin
        m_count = m_count + fault_count_t'(1);
      end
    end
  endtask

  // Stack entries only where the model depth covers them
  task automatic compare_outputs(input logic hof_now);
    int d;
    d = int'(m_depth);
    if (d > 0) check_value("top", m_stk[0], top);
    if (d > 1) check_value("second", m_stk[1], second);
    if (d > 2) check_value("third", m_stk[2], third);
    check_value("overflow_flag", 32'(m_flag), 32'(overflow_flag));
    check_value("overflow_count", 32'(m_count), 32'(overflow_count));
    check_value("halted", 32'(m_flag && hof_now), 32'(halted));
  endtask

  initial begin
    reset          = 1'b1;
    op             = op_nop;
    imm            = '0;
    fault_clear    = 1'b0;
    halt_on_fault  = 1'b0;
    m_depth        = '0;
    m_flag         = 1'b0;
    m_count        = '0;
    vectors_loaded = 1'b0;
    load_vectors();
    vectors_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY_NS);
    reset = 1'b0;
    for (int k = 0; k < num_vectors; k++) begin
      op            = op_t'(vec_op[k]);
      imm           = vec_imm[k];
      fault_clear   = vec_clear[k];
      halt_on_fault = vec_hof[k];
      @(posedge clk);
      apply_vector(vec_op[k], vec_imm[k], vec_clear[k], vec_hof[k]);
      // Outputs settle well before the next drive point
      #(SAMPLE_DELAY_NS);
      compare_outputs(vec_hof[k]);
      #(DRIVE_DELAY_NS - SAMPLE_DELAY_NS);
    end
    $display("STATUS: PASS");
    $finish;
  end

  // Limit scales with the number of vectors
  initial begin : watchdog
    longint limit_ns;
    wait (vectors_loaded);
    limit_ns = longint'(num_vectors + RESET_CYCLES + SLACK_CYCLES) * CLK_PERIOD_NS;
    #(limit_ns);
    $display("Watchdog: the run timed out after %0d ns", limit_ns);
    $display("STATUS: FAIL");
    $fatal(1, "Timeout");
  end

endmodule : tb_stack_core

`default_nettype wire

// ==== sources.f ====
hw/stack_pkg.sv
hw/isa_pkg.sv
hw/dstack_cell.sv
hw/dstack.sv
hw/stack_alu.sv
hw/fault_regs.sv
hw/stack_core.sv
tb/tb_stack_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the stack core testbench with Verilator, run it and scan the log for the result
verilator --binary --timing --assert -f sources.f --top-module tb_stack_core \
  -o tb_stack_core > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_stack_core > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
exit 0

// ==== tb/stack_input.txt ====
// Columns: op imm clear halt_on_fault, all hex
// op: 0 nop 1 push 2 drop 3 drop2 4 dup 5 add 6 sub 7 and 8 xor 9 rot
1 11111111 0 0
1 22222222 0 0
1 33333333 0 0
4 00000000 0 0
2 00000000 0 0
1 44444444 0 0
3 00000000 0 0
1 00000005 0 0
1 00000007 0 0
5 00000000 0 0
1 00000010 0 0
6 00000000 0 0
1 0000ff0f 0 0
7 00000000 0 0
1 a5a5a5a5 0 0
8 00000000 0 0
1 00000001 0 0
1 00000002 0 0
1 00000003 0 0
9 00000000 0 0
9 00000001 0 0
9 00000003 0 0
0 00000000 0 0
3 00000000 0 0
3 00000000 0 0
3 00000000 0 0
1 00000000 0 0
1 00000001 0 0
1 00000002 0 0
1 00000003 0 0
1 00000004 0 0
1 00000005 0 0
1 00000006 0 0
1 00000007 0 0
1 00000008 0 0
1 00000009 0 0
1 0000000a 0 0
1 0000000b 0 0
1 0000000c 0 0
1 0000000d 0 0
1 0000000e 0 0
1 0000000f 0 0
2 00000000 0 0
1 000000aa 0 0
1 000000bb 0 0
1 000000cc 0 1
5 00000000 0 1
0 00000000 1 1
1 000000dd 0 1
8 00000000 0 0
0 00000000 0 0
